/* src/radio_pkg.sv */
/*
 * Radio core package
 * Settings and readback address map, widths and the shared bus and sample types
 */
package radio_pkg;

   // ------------------------------------------------------------------
   // bus widths
   // ------------------------------------------------------------------
   localparam int SET_ADDR_W   = 8;
   localparam int SET_DATA_W   = 32;
   localparam int RB_DATA_W    = 64;

   localparam int GPIO_W       = 32;
   localparam int MISC_W       = 32;
   localparam int LED_W        = 3;
   localparam int SAMPLE_W     = 32;
   localparam int IQ_W         = 16;
   localparam int FE_CTRL_W    = 3;
   localparam int DB_REG_IDX_W = 2;

   // ------------------------------------------------------------------
   // address map
   // ------------------------------------------------------------------
   localparam logic [SET_ADDR_W-1:0] SR_DB_BASE    = 8'd160;
   localparam logic [SET_ADDR_W-1:0] SR_TX_FE_BASE = SR_DB_BASE + 8'd48;
   localparam logic [SET_ADDR_W-1:0] SR_RX_FE_BASE = SR_DB_BASE + 8'd64;
   localparam logic [SET_ADDR_W-1:0] RB_DB_BASE    = 8'd16;

   // local register index inside the daughterboard block
   localparam logic [DB_REG_IDX_W-1:0] DB_IDX_GPIO_OUT = 2'd0;
   localparam logic [DB_REG_IDX_W-1:0] DB_IDX_GPIO_DDR = 2'd1;
   localparam logic [DB_REG_IDX_W-1:0] DB_IDX_LED      = 2'd2;
   localparam logic [DB_REG_IDX_W-1:0] DB_IDX_MISC_OUT = 2'd3;

   // ------------------------------------------------------------------
   // types
   // ------------------------------------------------------------------
   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
   } rb_req_t;

   typedef struct packed {
      logic                    stb;
      logic [DB_REG_IDX_W-1:0] idx;
      logic [SET_DATA_W-1:0]   data;
   } db_write_t;

   typedef struct packed {
      logic [GPIO_W-1:0] gpio_out;
      logic [GPIO_W-1:0] gpio_ddr;
      logic [GPIO_W-1:0] gpio_in;
      logic [MISC_W-1:0] misc_out;
      logic [MISC_W-1:0] misc_in;
      logic [LED_W:0]    led_ctrl;   // top bit selects auto mode
   } db_status_t;

   typedef struct packed {
      logic signed [IQ_W-1:0] i;     // upper half
      logic signed [IQ_W-1:0] q;
   } iq_t;

   typedef union packed {
      logic [SAMPLE_W-1:0] raw;
      iq_t                 iq;
   } sample_u;

   // field order gives bit 0 swap, bit 1 neg i, bit 2 neg q
   typedef struct packed {
      logic neg_q;
      logic neg_i;
      logic swap_iq;
   } fe_ctrl_t;

endpackage

/* src/settings_decoder.sv */
/*
 * Settings decoder
 * Splits settings writes into daughterboard and front-end targets,
 * and serves the 64-bit readback word
 */
module settings_decoder
   import radio_pkg::*;
(
   input  logic                 radio_clk,
   input  logic                 i_rst,
   input  set_bus_t             i_set,
   input  rb_req_t              i_rb,
   input  db_status_t           i_db_status,
   output db_write_t            o_db_write,
   output fe_ctrl_t             o_rx_ctrl,
   output fe_ctrl_t             o_tx_ctrl,
   output logic [RB_DATA_W-1:0] o_rb_data
);

   logic [SET_ADDR_W-1:0] db_offset;
   logic                  db_hit;
   logic [RB_DATA_W-1:0]  rb_word;

   // ------------------------------------------------------------------
   // address compare
   // ------------------------------------------------------------------
   assign db_offset = i_set.addr - SR_DB_BASE;   // wraps below base
   assign db_hit    = (db_offset < SET_ADDR_W'(2**DB_REG_IDX_W));

   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
      begin
         o_db_write <= '0;
         o_rx_ctrl  <= '0;
         o_tx_ctrl  <= '0;
      end
      else
      begin
         o_db_write.stb  <= i_set.stb && db_hit;
         o_db_write.idx  <= db_offset[DB_REG_IDX_W-1:0];
         o_db_write.data <= i_set.data;

         if (i_set.stb && (i_set.addr == SR_RX_FE_BASE))
            o_rx_ctrl <= fe_ctrl_t'(i_set.data[FE_CTRL_W-1:0]);
         if (i_set.stb && (i_set.addr == SR_TX_FE_BASE))
            o_tx_ctrl <= fe_ctrl_t'(i_set.data[FE_CTRL_W-1:0]);
      end
   end

   // ------------------------------------------------------------------
   // readback mux
   // ------------------------------------------------------------------
   always_comb
   begin
      case (i_rb.addr)
         RB_DB_BASE:
            rb_word = {i_db_status.gpio_out, i_db_status.gpio_in};
         RB_DB_BASE + 8'd1:
            rb_word = {i_db_status.misc_out, i_db_status.misc_in};
         RB_DB_BASE + 8'd2:
            rb_word = {GPIO_W'(i_db_status.led_ctrl), i_db_status.gpio_ddr};
         default:
            rb_word = '0;   // unmapped address
      endcase
   end

   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
         o_rb_data <= '0;
      else if (i_rb.stb)
         o_rb_data <= rb_word;   // held until next strobe
   end

endmodule

/* src/db_gpio_regs.sv */
/*
 * Daughterboard registers
 * GPIO out and direction, radio LEDs with auto mode, misc out and misc in
 */
module db_gpio_regs
   import radio_pkg::*;
(
   input  logic              radio_clk,
   input  logic              i_rst,
   input  db_write_t         i_write,
   input  logic [GPIO_W-1:0] i_gpio_in,
   input  logic [MISC_W-1:0] i_misc_in,
   input  logic              i_rx_running,
   input  logic              i_tx_running,
   output logic [GPIO_W-1:0] o_gpio_out,
   output logic [GPIO_W-1:0] o_gpio_ddr,
   output logic [MISC_W-1:0] o_misc_out,
   output logic [LED_W-1:0]  o_radio_led,
   output db_status_t        o_status
);

   logic [LED_W:0]    led_ctrl;
   logic [MISC_W-1:0] misc_out_r;
   logic [MISC_W-1:0] misc_in_r;
   logic [LED_W-1:0]  led_next;

   // ------------------------------------------------------------------
   // register file
   // ------------------------------------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
      begin
         o_gpio_out <= '0;
         o_gpio_ddr <= '0;   // all pins input
         led_ctrl   <= '0;
         misc_out_r <= '0;
      end
      else if (i_write.stb)
      begin
         case (i_write.idx)
            DB_IDX_GPIO_OUT: o_gpio_out <= i_write.data[GPIO_W-1:0];
            DB_IDX_GPIO_DDR: o_gpio_ddr <= i_write.data[GPIO_W-1:0];
            DB_IDX_LED:      led_ctrl   <= i_write.data[LED_W:0];
            DB_IDX_MISC_OUT: misc_out_r <= i_write.data[MISC_W-1:0];
            default:         ;
         endcase
      end
   end

   // auto mode shows {rx, tx, off}
   assign led_next = led_ctrl[LED_W] ? {i_rx_running, i_tx_running, 1'b0}
                                     : led_ctrl[LED_W-1:0];

   // ------------------------------------------------------------------
   // output and input registers
   // ------------------------------------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
      begin
         o_misc_out  <= '0;
         misc_in_r   <= '0;
         o_radio_led <= '0;
      end
      else
      begin
         o_misc_out  <= misc_out_r;   // one more stage to the pins
         misc_in_r   <= i_misc_in;
         o_radio_led <= led_next;
      end
   end

   always_comb
   begin
      o_status.gpio_out = o_gpio_out;
      o_status.gpio_ddr = o_gpio_ddr;
      o_status.gpio_in  = i_gpio_in;
      o_status.misc_out = misc_out_r;
      o_status.misc_in  = misc_in_r;
      o_status.led_ctrl = led_ctrl;
   end

endmodule

/* src/rx_frontend.sv */
/*
 * Receive front end
 * I/Q swap and per-component negation of the ADC word
 */
module rx_frontend
   import radio_pkg::*;
(
   input  logic     radio_clk,
   input  logic     i_rst,
   input  fe_ctrl_t i_ctrl,
   input  sample_u  i_sample,
   input  logic     i_stb,
   output sample_u  o_sample,
   output logic     o_stb
);

   sample_u swapped;
   iq_t     corr;

   always_comb
   begin
      // swap by rotating the raw word halves
      if (i_ctrl.swap_iq)
         swapped.raw = {i_sample.raw[IQ_W-1:0], i_sample.raw[SAMPLE_W-1:IQ_W]};
      else
         swapped.raw = i_sample.raw;

      // 16-bit wrap, 8000 stays 8000
      corr.i = i_ctrl.neg_i ? -swapped.iq.i : swapped.iq.i;
      corr.q = i_ctrl.neg_q ? -swapped.iq.q : swapped.iq.q;
   end

   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
      begin
         o_sample <= '0;
         o_stb    <= 1'b0;
      end
      else
      begin
         o_stb <= i_stb;
         if (i_stb)
            o_sample.iq <= corr;   // hold while strobe low
      end
   end

endmodule

/* src/tx_frontend.sv */
/*
 * Transmit front end
 * Swap then negate on the I/Q pair, presented as the DAC word
 */
module tx_frontend
   import radio_pkg::*;
(
   input  logic     radio_clk,
   input  logic     i_rst,
   input  fe_ctrl_t i_ctrl,
   input  sample_u  i_sample,
   input  logic     i_stb,
   output sample_u  o_sample,
   output logic     o_stb
);

   iq_t swapped;
   iq_t corr;

   always_comb
   begin
      swapped = i_sample.iq;
      if (i_ctrl.swap_iq)
      begin
         swapped.i = i_sample.iq.q;
         swapped.q = i_sample.iq.i;
      end

      corr.i = i_ctrl.neg_i ? -swapped.i : swapped.i;   // two's-complement wrap
      corr.q = i_ctrl.neg_q ? -swapped.q : swapped.q;
   end

   always_ff @(posedge radio_clk)
   begin
      if (i_rst)
      begin
         o_sample <= '0;
         o_stb    <= 1'b0;
      end
      else
      begin
         o_stb <= i_stb;
         if (i_stb)
            o_sample.raw <= corr;   // dac word, I in upper half
      end
   end

endmodule

/* src/radio_core.sv */
/*
 * Radio core top level
 * Settings decode, daughterboard registers and the rx/tx front-end corrections
 */
module radio_core
   import radio_pkg::*;
(
   input  logic                 radio_clk,
   input  logic                 i_rst,
   input  set_bus_t             i_set,
   input  rb_req_t              i_rb,
   input  sample_u              i_rx,
   input  logic                 i_rx_stb,
   input  sample_u              i_tx,
   input  logic                 i_tx_stb,
   input  logic [GPIO_W-1:0]    i_db_gpio_in,
   input  logic [MISC_W-1:0]    i_misc_in,
   input  logic                 i_rx_running,
   input  logic                 i_tx_running,
   output logic [RB_DATA_W-1:0] o_rb_data,
   output sample_u              o_rx,
   output logic                 o_rx_stb,
   output sample_u              o_tx,
   output logic                 o_tx_stb,
   output logic [GPIO_W-1:0]    o_db_gpio_out,
   output logic [GPIO_W-1:0]    o_db_gpio_ddr,
   output logic [MISC_W-1:0]    o_misc_out,
   output logic [LED_W-1:0]     o_radio_led
);

   db_write_t  db_write;
   db_status_t db_status;
   fe_ctrl_t   rx_ctrl;
   fe_ctrl_t   tx_ctrl;

   settings_decoder u_settings_decoder (
      .radio_clk   (radio_clk),
      .i_rst       (i_rst),
      .i_set       (i_set),
      .i_rb        (i_rb),
      .i_db_status (db_status),
      .o_db_write  (db_write),
      .o_rx_ctrl   (rx_ctrl),
      .o_tx_ctrl   (tx_ctrl),
      .o_rb_data   (o_rb_data)
   );

   db_gpio_regs u_db_gpio_regs (
      .radio_clk    (radio_clk),
      .i_rst        (i_rst),
      .i_write      (db_write),
      .i_gpio_in    (i_db_gpio_in),
      .i_misc_in    (i_misc_in),
      .i_rx_running (i_rx_running),
      .i_tx_running (i_tx_running),
      .o_gpio_out   (o_db_gpio_out),
      .o_gpio_ddr   (o_db_gpio_ddr),
      .o_misc_out   (o_misc_out),
      .o_radio_led  (o_radio_led),
      .o_status     (db_status)
   );

   rx_frontend u_rx_frontend (
      .radio_clk (radio_clk),
      .i_rst     (i_rst),
      .i_ctrl    (rx_ctrl),
      .i_sample  (i_rx),
      .i_stb     (i_rx_stb),
      .o_sample  (o_rx),
      .o_stb     (o_rx_stb)
   );

   tx_frontend u_tx_frontend (
      .radio_clk (radio_clk),
      .i_rst     (i_rst),
      .i_ctrl    (tx_ctrl),
      .i_sample  (i_tx),
      .i_stb     (i_tx_stb),
      .o_sample  (o_tx),
      .o_stb     (o_tx_stb)
   );

endmodule

/* test/radio_core_tb.sv */
/*
 * Radio core testbench
 * LCG stimulus through settings, readback, GPIO, misc, LEDs and both front ends
 */
module radio_core_tb
   import radio_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int GPIO_ROUNDS     = 4;
   localparam int FE_SAMPLES      = 16;
   localparam int LED_AUTO_CYCLES = 24;
   // rough cycle cost of each test, four times over
   localparam int TIMEOUT_CYCLES  = 4 * (GPIO_ROUNDS * 24 + 2 * 8 * (FE_SAMPLES + 4)
                                         + 8 * 6 + LED_AUTO_CYCLES + 40);

   logic                 radio_clk;
   logic                 i_rst;
   set_bus_t             i_set;
   rb_req_t              i_rb;
   sample_u              i_rx;
   logic                 i_rx_stb;
   sample_u              i_tx;
   logic                 i_tx_stb;
   logic [GPIO_W-1:0]    i_db_gpio_in;
   logic [MISC_W-1:0]    i_misc_in;
   logic                 i_rx_running;
   logic                 i_tx_running;
   logic [RB_DATA_W-1:0] o_rb_data;
   sample_u              o_rx;
   logic                 o_rx_stb;
   sample_u              o_tx;
   logic                 o_tx_stb;
   logic [GPIO_W-1:0]    o_db_gpio_out;
   logic [GPIO_W-1:0]    o_db_gpio_ddr;
   logic [MISC_W-1:0]    o_misc_out;
   logic [LED_W-1:0]     o_radio_led;

   // ------------------------------------------------------------------
   // reference model state and counters
   // ------------------------------------------------------------------
   logic [31:0]         rng_state  = 32'h94e4_aad2;
   logic [GPIO_W-1:0]   gpio_model = '0;
   logic [GPIO_W-1:0]   ddr_model  = '0;
   logic [MISC_W-1:0]   misc_model = '0;
   logic [LED_W:0]      led_model  = '0;
   logic [SAMPLE_W-1:0] rx_hold    = '0;
   logic [SAMPLE_W-1:0] tx_hold    = '0;
   int error_count   = 0;
   int check_count   = 0;
   int test_count    = 0;
   int test_mark     = 0;
   int rx_stb_errors = 0;
   int tx_stb_errors = 0;
   int cycle_count   = 0;

   radio_core u_radio_core (.*);

   initial
   begin
      radio_clk = 1'b0;
      forever #50 radio_clk = ~radio_clk;   // 100 ns period
   end

   always @(posedge radio_clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("run stopped: no finish after %0d cycles", cycle_count);
         $display("Finished with errors");
         $finish;
      end
   end

   // strobes follow the input strobe one edge later
   assert property (@(posedge radio_clk) disable iff (i_rst) o_rx_stb == $past(i_rx_stb))
   else
   begin
      rx_stb_errors++;
      $display("** Error o_rx_stb: expected 0x%h, got 0x%h at %0t",
               !$sampled(o_rx_stb), $sampled(o_rx_stb), $time);
   end

   assert property (@(posedge radio_clk) disable iff (i_rst) o_tx_stb == $past(i_tx_stb))
   else
   begin
      tx_stb_errors++;
      $display("** Error o_tx_stb: expected 0x%h, got 0x%h at %0t",
               !$sampled(o_tx_stb), $sampled(o_tx_stb), $time);
   end

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------
   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // swap first, then two's-complement negate each half
   function automatic logic [SAMPLE_W-1:0] correct_sample(input logic [SAMPLE_W-1:0] raw,
                                                          input logic [FE_CTRL_W-1:0] ctrl);
      logic [IQ_W-1:0] i_val;
      logic [IQ_W-1:0] q_val;
      i_val = ctrl[0] ? raw[15:0] : raw[31:16];
      q_val = ctrl[0] ? raw[31:16] : raw[15:0];
      if (ctrl[1])
         i_val = ~i_val + 16'd1;
      if (ctrl[2])
         q_val = ~q_val + 16'd1;
      return {i_val, q_val};
   endfunction

   function automatic int total_errors();
      return error_count + rx_stb_errors + tx_stb_errors;
   endfunction

   task automatic compare_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      check_count++;
      assert (actual === expected)
      else
      begin
         error_count++;
         $display("** Error %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
      end
   endtask

   task automatic begin_test();
      test_mark = total_errors();
   endtask

   task automatic end_test(input string name);
      test_count++;
      if (total_errors() == test_mark)
         $display("test %s passed", name);
      else
         $display("test %s failed with %0d errors", name, total_errors() - test_mark);
   endtask

   task automatic skip_edges(input int n);
      repeat (n) @(posedge radio_clk);
      @(negedge radio_clk);   // sample mid cycle
   endtask

   task automatic write_setting(input logic [SET_ADDR_W-1:0] addr,
                                input logic [SET_DATA_W-1:0] data);
      @(posedge radio_clk);
      i_set.stb  <= 1'b1;
      i_set.addr <= addr;
      i_set.data <= data;
      @(posedge radio_clk);
      i_set.stb  <= 1'b0;
   endtask

   task automatic read_back(input logic [SET_ADDR_W-1:0] addr,
                            input logic [RB_DATA_W-1:0] expected);
      @(posedge radio_clk);
      i_rb.stb  <= 1'b1;
      i_rb.addr <= addr;
      @(posedge radio_clk);
      i_rb.stb  <= 1'b0;
      @(negedge radio_clk);
      compare_value("o_rb_data", expected, o_rb_data);
   endtask

   // one control word, then a stream of strobed samples with gaps
   task automatic run_frontend(input logic tx_path, input logic [FE_CTRL_W-1:0] ctrl);
      logic [SAMPLE_W-1:0] raw;
      logic [SAMPLE_W-1:0] prev_raw;
      logic [SAMPLE_W-1:0] expected;
      logic [31:0]         pick;
      logic                stb;
      logic                prev_stb;
      prev_raw = '0;
      prev_stb = 1'b0;
      write_setting(tx_path ? SR_TX_FE_BASE : SR_RX_FE_BASE, {29'd0, ctrl});
      for (int k = 0; k <= FE_SAMPLES; k++)
      begin
         raw  = next_random();
         pick = next_random();
         if (k == 0)
            raw[31:16] = 16'h8000;   // most negative I
         if (k == 1)
            raw[15:0] = 16'h8000;
         stb = (k < FE_SAMPLES) && (k < 2 || pick[0]);
         @(posedge radio_clk);
         if (tx_path)
         begin
            i_tx.raw <= raw;
            i_tx_stb <= stb;
         end
         else
         begin
            i_rx.raw <= raw;
            i_rx_stb <= stb;
         end
         @(negedge radio_clk);
         if (prev_stb && tx_path)
            tx_hold = correct_sample(prev_raw, ctrl);
         if (prev_stb && !tx_path)
            rx_hold = correct_sample(prev_raw, ctrl);
         expected = tx_path ? tx_hold : rx_hold;
         compare_value(tx_path ? "o_tx" : "o_rx", 64'(expected),
                       64'(tx_path ? o_tx.raw : o_rx.raw));
         prev_raw = raw;
         prev_stb = stb;
      end
   endtask

   // ------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------
   initial
   begin
      logic [31:0] value;
      logic [31:0] in_word;
      logic [1:0]  prev_run;
      i_rst        <= 1'b1;
      i_set        <= '0;
      i_rb         <= '0;
      i_rx         <= '0;
      i_rx_stb     <= 1'b0;
      i_tx         <= '0;
      i_tx_stb     <= 1'b0;
      i_db_gpio_in <= '0;
      i_misc_in    <= '0;
      i_rx_running <= 1'b0;
      i_tx_running <= 1'b0;
      repeat (2) @(posedge radio_clk);
      i_rst <= 1'b0;
      @(negedge radio_clk);

      begin_test();
      compare_value("o_db_gpio_out", 64'd0, 64'(o_db_gpio_out));
      compare_value("o_db_gpio_ddr", 64'd0, 64'(o_db_gpio_ddr));
      compare_value("o_misc_out", 64'd0, 64'(o_misc_out));
      compare_value("o_radio_led", 64'd0, 64'(o_radio_led));
      compare_value("o_rx_stb", 64'd0, 64'(o_rx_stb));
      compare_value("o_tx_stb", 64'd0, 64'(o_tx_stb));
      end_test("reset");

      begin_test();
      for (int r = 0; r < GPIO_ROUNDS; r++)
      begin
         value = next_random();
         write_setting(SR_DB_BASE, value);
         skip_edges(0);   // one edge after the write, old value
         compare_value("o_db_gpio_out", 64'(gpio_model), 64'(o_db_gpio_out));
         gpio_model = value;
         skip_edges(1);
         compare_value("o_db_gpio_out", 64'(gpio_model), 64'(o_db_gpio_out));
         value = next_random();
         write_setting(SR_DB_BASE + 8'd1, value);
         skip_edges(0);
         compare_value("o_db_gpio_ddr", 64'(ddr_model), 64'(o_db_gpio_ddr));
         ddr_model = value;
         skip_edges(1);
         compare_value("o_db_gpio_ddr", 64'(ddr_model), 64'(o_db_gpio_ddr));
         in_word = next_random();
         @(posedge radio_clk);
         i_db_gpio_in <= in_word;
         read_back(RB_DB_BASE, {gpio_model, in_word});
         read_back(RB_DB_BASE + 8'd2, {28'd0, led_model, ddr_model});
      end
      read_back(8'h33, '0);
      read_back(RB_DB_BASE + 8'd3, '0);
      end_test("gpio");

      begin_test();
      value = next_random();
      write_setting(SR_DB_BASE + 8'd3, value);
      skip_edges(1);   // still old two edges after the write
      compare_value("o_misc_out", 64'(misc_model), 64'(o_misc_out));
      misc_model = value;
      skip_edges(1);
      compare_value("o_misc_out", 64'(misc_model), 64'(o_misc_out));
      in_word = next_random();
      @(posedge radio_clk);
      i_misc_in <= in_word;
      read_back(RB_DB_BASE + 8'd1, {misc_model, in_word});
      end_test("misc");

      begin_test();
      for (int c = 0; c < 8; c++)
         run_frontend(1'b0, 3'(c));
      end_test("receive");

      begin_test();
      for (int c = 0; c < 8; c++)
         run_frontend(1'b1, 3'(c));
      compare_value("o_rx", 64'(rx_hold), 64'(o_rx.raw));   // rx path untouched
      end_test("transmit");

      begin_test();
      for (int v = 0; v < 8; v++)
      begin
         led_model = {1'b0, 3'(v)};
         write_setting(SR_DB_BASE + 8'd2, {28'd0, led_model});
         skip_edges(2);
         compare_value("o_radio_led", 64'(led_model[LED_W-1:0]), 64'(o_radio_led));
      end
      led_model = 4'hf;   // auto mode over all manual bits set
      write_setting(SR_DB_BASE + 8'd2, {28'd0, led_model});
      skip_edges(2);
      read_back(RB_DB_BASE + 8'd2, {28'd0, led_model, ddr_model});
      prev_run = 2'b00;
      for (int c = 0; c < LED_AUTO_CYCLES; c++)
      begin
         value = next_random();
         @(posedge radio_clk);
         i_rx_running <= value[0];
         i_tx_running <= value[1];
         @(negedge radio_clk);
         compare_value("o_radio_led", 64'({prev_run, 1'b0}), 64'(o_radio_led));
         prev_run = {value[0], value[1]};
      end
      end_test("leds");

      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, total_errors());
      if (total_errors() == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

/* radio_core.f */
src/radio_pkg.sv
src/settings_decoder.sv
src/db_gpio_regs.sv
src/rx_frontend.sv
src/tx_frontend.sv
src/radio_core.sv
test/radio_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the radio_core testbench with Verilator and run it.
# The exit status is zero only when the run reports a clean finish.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
   --top-module radio_core_tb -f radio_core.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/Vradio_core_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
   exit 0
else
   echo "simulation did not finish cleanly"
   exit 1
fi
